/* project.f */
verilog/bp_pkg.sv
verilog/bp_table.sv
verilog/bp_lookup.sv
verilog/bp_resolve.sv
verilog/bp_csr.sv
verilog/branch_predictor.sv
testbench/bp_props.sv
testbench/tb_branch_predictor.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f project.f --top-module tb_branch_predictor \
  && ./obj_dir/Vtb_branch_predictor > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "No errors" sim.log 2>/dev/null && ! grep -q "Errors found" sim.log \
  && echo "PASS" || { echo "FAIL"; exit 1; }

/* testbench/bp_props.sv */
module bp_props (
  input logic clk,
  input logic rst_n,
  input logic flush,
  input logic stall,
  input logic ex_valid
);

  // a flush squashes the wrong-path instruction behind the branch
  flush_squashes: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !ex_valid)
    else $error("execute stage still valid in the cycle after a flush");

  // held entry enters execute as a bubble so nothing trains twice
  stall_bubble: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !ex_valid)
    else $error("execute stage valid in the cycle after a stall");

  quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !flush)
    else $error("flush high in the first cycle after reset");

endmodule

bind branch_predictor bp_props u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .flush    (flush),
  .stall    (stall),
  .ex_valid (ex_valid)
);

/* testbench/bp_tests.txt */
// columns: ctrl pc target, hex, one decode slot per line
// ctrl bits: 0 branch, 1 taken, 2 stall first, 3 csr write, 5:4 csr addr, 6 wdata, 7 empty slot
11 00001000 00001040
11 00001000 00001040
11 00001000 00001040
13 00001004 00001080
90 00000000 00000000
13 00001004 00001080
13 00001004 00001080
13 00001004 00001080
11 00001004 00001080
90 00000000 00000000
13 00001004 00001080
13 00001100 00001200
90 00000000 00000000
11 00001000 00001040
17 00001004 00001080
12 00001008 00001400
a0 00000000 00000000
88 00000000 00000000
13 00001004 00001080
13 00001100 00001200
80 00000000 00000000
c8 00000000 00000000
13 00001004 00001080
98 00000000 00000000
a8 00000000 00000000
23 00001100 00001300

/* testbench/tb_branch_predictor.sv */
module tb_branch_predictor;

  localparam int index_bits     = 6;
  localparam int max_records    = 64;
  localparam int random_records = 12;
  localparam logic [6:0] opcode_alu = 7'b0010011; // addi, never a branch

  logic                    clk;
  logic                    rst_n;
  logic                    dec_valid;
  logic [bp_pkg::xlen-1:0] dec_pc;
  logic [6:0]              dec_opcode;
  logic                    stall;
  logic                    ex_taken;
  logic [bp_pkg::xlen-1:0] ex_target;
  logic                    csr_we;
  bp_pkg::csr_addr_t       csr_addr;
  logic [bp_pkg::xlen-1:0] csr_wdata;
  logic                    pred_taken;
  logic [bp_pkg::xlen-1:0] pred_pc;
  logic                    flush;
  logic [bp_pkg::xlen-1:0] redirect_pc;
  logic [bp_pkg::xlen-1:0] csr_rdata;

  // ctrl byte: 0 branch, 1 taken, 2 stall first, 3 csr write, 5:4 csr addr,
  // 6 write data, 7 empty decode slot
  logic [31:0]             raw [0:3*max_records-1];
  logic [7:0]              rec_ctrl [0:max_records-1];
  logic [bp_pkg::xlen-1:0] rec_pc [0:max_records-1];
  logic [bp_pkg::xlen-1:0] rec_target [0:max_records-1];
  int                      nrec;
  int                      cycle_count = 0;
  int                      cycle_limit = 1000;
  integer                  seed;

  bp_pkg::counter_t        model_cnt [2**index_bits];
  bp_pkg::btb_entry_t      model_btb [2**index_bits];
  logic                    model_enable;
  logic [bp_pkg::xlen-1:0] model_branches;
  logic [bp_pkg::xlen-1:0] model_mispredicts;
  logic                    pipe_valid; // model of the execute stage
  logic [bp_pkg::xlen-1:0] pipe_pc;
  logic                    pipe_pred_taken;
  logic [bp_pkg::xlen-1:0] pipe_pred_pc;
  logic                    pipe_taken;
  logic [bp_pkg::xlen-1:0] pipe_target;

  branch_predictor #(
    .index_bits (index_bits)
  ) uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      stop_run($sformatf("the run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_pred(input logic got_taken, input logic [bp_pkg::xlen-1:0] got_pc,
                            input logic exp_taken, input logic [bp_pkg::xlen-1:0] exp_pc);
    if (got_taken !== exp_taken || got_pc !== exp_pc) begin
      stop_run($sformatf("MISMATCH at %0t: prediction %b %h, expected %b %h",
                         $time, got_taken, got_pc, exp_taken, exp_pc));
    end
  endtask

  task automatic check_redirect(input logic got_flush, input logic [bp_pkg::xlen-1:0] got_pc,
                                input logic exp_flush, input logic [bp_pkg::xlen-1:0] exp_pc,
                                input logic pc_valid);
    if (got_flush !== exp_flush) begin
      stop_run($sformatf("MISMATCH at %0t: flush %b, expected %b", $time, got_flush, exp_flush));
    end else if (pc_valid && got_pc !== exp_pc) begin
      stop_run($sformatf("MISMATCH at %0t: redirect_pc %h, expected %h", $time, got_pc, exp_pc));
    end
  endtask

  task automatic check_csr(input logic [bp_pkg::xlen-1:0] got, input logic [bp_pkg::xlen-1:0] exp,
                           input bp_pkg::csr_addr_t addr);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t: csr %0d reads %0d, expected %0d",
                         $time, addr, got, exp));
    end
  endtask

  function automatic logic [index_bits-1:0] table_index(input logic [bp_pkg::xlen-1:0] pc);
    return pc[index_bits+1:2];
  endfunction

  function automatic bp_pkg::counter_t next_counter(input bp_pkg::counter_t c, input logic taken);
    if (taken && c != bp_pkg::strong_taken) begin
      return bp_pkg::counter_t'(c + 2'd1);
    end
    if (!taken && c != bp_pkg::strong_not_taken) begin
      return bp_pkg::counter_t'(c - 2'd1);
    end
    return c; // saturated
  endfunction

  function automatic logic [bp_pkg::xlen-1:0] expected_csr(input bp_pkg::csr_addr_t addr);
    case (addr)
      bp_pkg::csr_ctrl:             return {31'b0, model_enable};
      bp_pkg::csr_branch_count:     return model_branches;
      bp_pkg::csr_mispredict_count: return model_mispredicts;
      default:                      return '0;
    endcase
  endfunction

  task automatic reset_model();
    model_cnt         = '{default: bp_pkg::weak_not_taken};
    model_btb         = '{default: '0};
    model_enable      = 1'b1;
    model_branches    = '0;
    model_mispredicts = '0;
    pipe_valid        = 1'b0;
    pipe_pc           = '0;
    pipe_pred_taken   = 1'b0;
    pipe_pred_pc      = '0;
    pipe_taken        = 1'b0;
    pipe_target       = '0;
  endtask

  // one clock: record i at decode, the previous branch at execute
  task automatic apply_cycle(input int i, input logic hold);
    logic [7:0]              c;
    logic                    is_branch;
    logic                    do_write;
    logic                    exp_taken;
    logic                    exp_flush;
    logic [bp_pkg::xlen-1:0] exp_pc;
    logic [bp_pkg::xlen-1:0] exp_redirect;
    logic [index_bits-1:0]   d;
    logic [index_bits-1:0]   e;
    bp_pkg::csr_addr_t       addr;
    c         = rec_ctrl[i];
    is_branch = !c[7] && c[0];
    do_write  = c[3] && !hold; // write lands once, in the unstalled cycle
    addr      = bp_pkg::csr_addr_t'(c[5:4]);
    @(posedge clk);
    dec_valid  <= !c[7];
    dec_pc     <= rec_pc[i];
    dec_opcode <= c[0] ? bp_pkg::opcode_branch : opcode_alu;
    stall      <= hold;
    ex_taken   <= pipe_taken;
    ex_target  <= pipe_target;
    csr_we     <= do_write;
    csr_addr   <= addr;
    csr_wdata  <= {31'b0, c[6]};
    @(negedge clk);
    d         = table_index(rec_pc[i]);
    exp_taken = is_branch && model_enable && model_btb[d].valid && model_btb[d].tag == rec_pc[i]
                && (model_cnt[d] == bp_pkg::weak_taken || model_cnt[d] == bp_pkg::strong_taken);
    exp_pc    = exp_taken ? model_btb[d].target : rec_pc[i] + 32'd4;
    exp_flush = pipe_valid && (pipe_pred_taken != pipe_taken ||
                               (pipe_pred_taken && pipe_pred_pc != pipe_target));
    exp_redirect = pipe_taken ? pipe_target : pipe_pc + 32'd4;
    check_pred(pred_taken, pred_pc, exp_taken, exp_pc);
    check_redirect(flush, redirect_pc, exp_flush, exp_redirect, pipe_valid);
    check_csr(csr_rdata, expected_csr(addr), addr);
    if (pipe_valid) begin // training at the closing edge
      e            = table_index(pipe_pc);
      model_cnt[e] = next_counter(model_cnt[e], pipe_taken);
      if (pipe_taken) begin
        model_btb[e] = '{valid: 1'b1, tag: pipe_pc, target: pipe_target};
      end
      model_branches = model_branches + 32'd1;
      if (exp_flush) begin
        model_mispredicts = model_mispredicts + 32'd1;
      end
    end
    if (do_write) begin
      case (addr)
        bp_pkg::csr_ctrl:             model_enable = c[6];
        bp_pkg::csr_branch_count:     model_branches = '0;
        bp_pkg::csr_mispredict_count: model_mispredicts = '0;
        default: ;
      endcase
    end
    if (!hold) begin
      pipe_pc         = rec_pc[i];
      pipe_pred_taken = exp_taken;
      pipe_pred_pc    = exp_pc;
      pipe_taken      = c[1];
      pipe_target     = rec_target[i];
    end
    pipe_valid = is_branch && !hold && !exp_flush; // squashed by a flush
  endtask

  initial begin
    logic [31:0] r;
    rst_n      = 1'b0;
    dec_valid  = 1'b0;
    dec_pc     = '0;
    dec_opcode = opcode_alu;
    stall      = 1'b0;
    ex_taken   = 1'b0;
    ex_target  = '0;
    csr_we     = 1'b0;
    csr_addr   = bp_pkg::csr_ctrl;
    csr_wdata  = '0;
    raw        = '{default: 32'hffff_ffff}; // marks the end of the file data
    $readmemh("testbench/bp_tests.txt", raw);
    nrec = 0;
    while (nrec < max_records - random_records - 1 && raw[3*nrec] != 32'hffff_ffff) begin
      rec_ctrl[nrec]   = raw[3*nrec][7:0];
      rec_pc[nrec]     = raw[3*nrec+1];
      rec_target[nrec] = raw[3*nrec+2];
      nrec++;
    end
    if (nrec == 0) begin
      stop_run("no test records could be read from testbench/bp_tests.txt");
    end
    seed = 32'hcb55;
    repeat (random_records) begin // a few pcs hit hard, so targets collide
      r                = $random(seed);
      rec_ctrl[nrec]   = {6'b000100, r[0], 1'b1};
      rec_pc[nrec]     = 32'h0000_2000 + {27'b0, r[3:1], 2'b00};
      rec_target[nrec] = 32'h0000_3000 + {28'b0, r[5:4], 2'b00};
      nrec++;
    end
    rec_ctrl[nrec]   = 8'h90; // empty slot drains the last branch
    rec_pc[nrec]     = '0;
    rec_target[nrec] = '0;
    nrec++;
    cycle_limit = 2 * nrec + 20;
    reset_model();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < nrec; i++) begin
      if (rec_ctrl[i][2]) begin
        apply_cycle(i, 1'b1);
      end
      apply_cycle(i, 1'b0);
    end
    $display("No errors");
    $finish;
  end

endmodule

/* verilog/bp_csr.sv */
module bp_csr (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    csr_we,
  input  bp_pkg::csr_addr_t       csr_addr,
  input  logic [bp_pkg::xlen-1:0] csr_wdata,
  input  logic                    branch_done,
  input  logic                    mispredict,
  output logic [bp_pkg::xlen-1:0] csr_rdata,
  output logic                    enable
);

  logic [bp_pkg::xlen-1:0] branch_cnt;
  logic [bp_pkg::xlen-1:0] mispredict_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable <= 1'b1; // predictor on out of reset
    end else if (csr_we && (csr_addr == bp_pkg::csr_ctrl)) begin
      enable <= csr_wdata[0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      branch_cnt <= '0;
    end else if (csr_we && (csr_addr == bp_pkg::csr_branch_count)) begin
      branch_cnt <= '0; // any write clears
    end else if (branch_done) begin
      branch_cnt <= branch_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mispredict_cnt <= '0;
    end else if (csr_we && (csr_addr == bp_pkg::csr_mispredict_count)) begin
      mispredict_cnt <= '0;
    end else if (mispredict) begin
      mispredict_cnt <= mispredict_cnt + 1'b1;
    end
  end

  always_comb begin
    case (csr_addr)
      bp_pkg::csr_ctrl:             csr_rdata = {{(bp_pkg::xlen-1){1'b0}}, enable};
      bp_pkg::csr_branch_count:     csr_rdata = branch_cnt;
      bp_pkg::csr_mispredict_count: csr_rdata = mispredict_cnt;
      default:                      csr_rdata = '0; // unmapped
    endcase
  end

endmodule

/* verilog/bp_lookup.sv */
module bp_lookup #(
  parameter int index_bits = 6
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        dec_valid,
  input  logic [bp_pkg::xlen-1:0]     dec_pc,
  input  logic [6:0]                  dec_opcode,
  input  logic                        stall,
  input  logic                        flush,
  input  logic                        enable,

  output logic [index_bits-1:0]       cnt_index,
  input  bp_pkg::counter_t            cnt_data,

  output logic [index_bits-1:0]       btb_index,
  input  bp_pkg::btb_entry_t          btb_data,

  output logic                        pred_taken,
  output logic [bp_pkg::xlen-1:0]     pred_pc,
  output logic                        ex_valid,
  output logic [bp_pkg::xlen-1:0]     ex_pc,
  output logic                        ex_pred_taken,
  output logic [bp_pkg::xlen-1:0]     ex_pred_pc
);

  logic is_branch;
  logic cnt_taken;
  logic btb_hit;

  assign cnt_index = dec_pc[index_bits+1:2]; // word aligned pc
  assign btb_index = dec_pc[index_bits+1:2];

  assign is_branch = dec_valid && (dec_opcode == bp_pkg::opcode_branch);
  assign cnt_taken = (cnt_data == bp_pkg::weak_taken) || (cnt_data == bp_pkg::strong_taken);
  assign btb_hit   = btb_data.valid && (btb_data.tag == dec_pc);

  assign pred_taken = is_branch && enable && cnt_taken && btb_hit;
  assign pred_pc    = pred_taken ? btb_data.target : dec_pc + bp_pkg::pc_step;

  // decode to execute stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else if (flush || stall) begin
      ex_valid <= 1'b0; // squash wrong path, or bubble on a held entry
    end else begin
      ex_valid <= is_branch;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_pc         <= dec_pc;
      ex_pred_taken <= pred_taken;
      ex_pred_pc    <= pred_pc;
    end
  end

endmodule

/* verilog/bp_pkg.sv */
package bp_pkg;

  localparam int xlen = 32;

  localparam logic [6:0] opcode_branch = 7'b1100011; // beq, bne, blt and friends

  localparam logic [xlen-1:0] pc_step = 'd4; // fall-through distance

  // 2-bit saturating direction counter
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } counter_t;

  // direct-mapped target buffer entry, full pc kept as tag
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] tag;
    logic [xlen-1:0] target;
  } btb_entry_t;

  typedef enum logic [1:0] {
    csr_ctrl             = 2'd0, // bit 0 is enable
    csr_branch_count     = 2'd1,
    csr_mispredict_count = 2'd2
  } csr_addr_t;

endpackage

/* verilog/bp_resolve.sv */
module bp_resolve #(
  parameter int index_bits = 6
) (
  input  logic                        ex_valid,
  input  logic [bp_pkg::xlen-1:0]     ex_pc,
  input  logic                        ex_pred_taken,
  input  logic [bp_pkg::xlen-1:0]     ex_pred_pc,
  input  logic                        ex_taken,
  input  logic [bp_pkg::xlen-1:0]     ex_target,

  output logic [index_bits-1:0]       cnt_index,
  input  bp_pkg::counter_t            cnt_data,
  output logic                        cnt_we,
  output bp_pkg::counter_t            cnt_wdata,

  output logic [index_bits-1:0]       btb_index,
  output logic                        btb_we,
  output bp_pkg::btb_entry_t          btb_wdata,

  output logic                        flush,
  output logic [bp_pkg::xlen-1:0]     redirect_pc,
  output logic                        branch_done,
  output logic                        mispredict
);

  logic dir_wrong;
  logic target_wrong;

  assign cnt_index = ex_pc[index_bits+1:2];
  assign btb_index = ex_pc[index_bits+1:2];

  assign dir_wrong    = ex_pred_taken != ex_taken;
  assign target_wrong = ex_pred_taken && (ex_pred_pc != ex_target);

  assign mispredict  = ex_valid && (dir_wrong || target_wrong);
  assign flush       = mispredict;
  assign branch_done = ex_valid;

  assign redirect_pc = ex_taken ? ex_target : ex_pc + bp_pkg::pc_step;

  // counter moves one step toward the outcome
  always_comb begin
    cnt_wdata = cnt_data;
    if (ex_taken) begin
      case (cnt_data)
        bp_pkg::strong_not_taken: cnt_wdata = bp_pkg::weak_not_taken;
        bp_pkg::weak_not_taken:   cnt_wdata = bp_pkg::weak_taken;
        bp_pkg::weak_taken:       cnt_wdata = bp_pkg::strong_taken;
        default:                  cnt_wdata = bp_pkg::strong_taken;
      endcase
    end else begin
      case (cnt_data)
        bp_pkg::strong_taken:   cnt_wdata = bp_pkg::weak_taken;
        bp_pkg::weak_taken:     cnt_wdata = bp_pkg::weak_not_taken;
        bp_pkg::weak_not_taken: cnt_wdata = bp_pkg::strong_not_taken;
        default:                cnt_wdata = bp_pkg::strong_not_taken;
      endcase
    end
  end

  assign cnt_we = ex_valid;

  // only taken branches allocate a target
  assign btb_we           = ex_valid && ex_taken;
  assign btb_wdata.valid  = 1'b1;
  assign btb_wdata.tag    = ex_pc;
  assign btb_wdata.target = ex_target;

endmodule

/* verilog/bp_table.sv */
module bp_table #(
  parameter type    entry_t     = logic [1:0],
  parameter int     index_bits  = 6,
  parameter entry_t reset_value = entry_t'(0)
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // decode side read
  input  logic [index_bits-1:0] rd_a_index,
  output entry_t                rd_a_data,

  // execute side read
  input  logic [index_bits-1:0] rd_b_index,
  output entry_t                rd_b_data,

  input  logic                  we,
  input  logic [index_bits-1:0] wr_index,
  input  entry_t                wr_data
);

  localparam int depth = 2 ** index_bits;

  entry_t mem [depth];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= reset_value;
      end
    end else if (we) begin
      mem[wr_index] <= wr_data;
    end
  end

  // reads see the old entry during a same-cycle write
  assign rd_a_data = mem[rd_a_index];
  assign rd_b_data = mem[rd_b_index];

endmodule

/* verilog/branch_predictor.sv */
module branch_predictor #(
  parameter int index_bits = 6
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    dec_valid,
  input  logic [bp_pkg::xlen-1:0] dec_pc,
  input  logic [6:0]              dec_opcode,
  input  logic                    stall,

  input  logic                    ex_taken,
  input  logic [bp_pkg::xlen-1:0] ex_target,

  output logic                    pred_taken,
  output logic [bp_pkg::xlen-1:0] pred_pc,
  output logic                    flush,
  output logic [bp_pkg::xlen-1:0] redirect_pc,

  input  logic                    csr_we,
  input  bp_pkg::csr_addr_t       csr_addr,
  input  logic [bp_pkg::xlen-1:0] csr_wdata,
  output logic [bp_pkg::xlen-1:0] csr_rdata
);

  logic [index_bits-1:0]   dec_cnt_index;
  logic [index_bits-1:0]   dec_btb_index;
  bp_pkg::counter_t        dec_cnt_data;
  bp_pkg::btb_entry_t      dec_btb_data;

  logic [index_bits-1:0]   ex_cnt_index;
  logic [index_bits-1:0]   ex_btb_index;
  bp_pkg::counter_t        ex_cnt_data;
  logic                    cnt_we;
  bp_pkg::counter_t        cnt_wdata;
  logic                    btb_we;
  bp_pkg::btb_entry_t      btb_wdata;

  logic                    ex_valid;
  logic [bp_pkg::xlen-1:0] ex_pc;
  logic                    ex_pred_taken;
  logic [bp_pkg::xlen-1:0] ex_pred_pc;

  logic                    enable;
  logic                    branch_done;
  logic                    mispredict;

  bp_table #(
    .entry_t     (bp_pkg::counter_t),
    .index_bits  (index_bits),
    .reset_value (bp_pkg::weak_not_taken)
  ) counter_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_a_index (dec_cnt_index),
    .rd_a_data  (dec_cnt_data),
    .rd_b_index (ex_cnt_index),
    .rd_b_data  (ex_cnt_data),
    .we         (cnt_we),
    .wr_index   (ex_cnt_index),
    .wr_data    (cnt_wdata)
  );

  // execute read of the target table is not needed, ex_pred_pc carries it
  bp_table #(
    .entry_t     (bp_pkg::btb_entry_t),
    .index_bits  (index_bits),
    .reset_value (bp_pkg::btb_entry_t'('0))
  ) target_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_a_index (dec_btb_index),
    .rd_a_data  (dec_btb_data),
    .rd_b_index (ex_btb_index),
    .rd_b_data  (),
    .we         (btb_we),
    .wr_index   (ex_btb_index),
    .wr_data    (btb_wdata)
  );

  bp_lookup #(
    .index_bits (index_bits)
  ) u_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .dec_valid     (dec_valid),
    .dec_pc        (dec_pc),
    .dec_opcode    (dec_opcode),
    .stall         (stall),
    .flush         (flush),
    .enable        (enable),
    .cnt_index     (dec_cnt_index),
    .cnt_data      (dec_cnt_data),
    .btb_index     (dec_btb_index),
    .btb_data      (dec_btb_data),
    .pred_taken    (pred_taken),
    .pred_pc       (pred_pc),
    .ex_valid      (ex_valid),
    .ex_pc         (ex_pc),
    .ex_pred_taken (ex_pred_taken),
    .ex_pred_pc    (ex_pred_pc)
  );

  bp_resolve #(
    .index_bits (index_bits)
  ) u_resolve (
    .ex_valid      (ex_valid),
    .ex_pc         (ex_pc),
    .ex_pred_taken (ex_pred_taken),
    .ex_pred_pc    (ex_pred_pc),
    .ex_taken      (ex_taken),
    .ex_target     (ex_target),
    .cnt_index     (ex_cnt_index),
    .cnt_data      (ex_cnt_data),
    .cnt_we        (cnt_we),
    .cnt_wdata     (cnt_wdata),
    .btb_index     (ex_btb_index),
    .btb_we        (btb_we),
    .btb_wdata     (btb_wdata),
    .flush         (flush),
    .redirect_pc   (redirect_pc),
    .branch_done   (branch_done),
    .mispredict    (mispredict)
  );

  bp_csr u_csr (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_we      (csr_we),
    .csr_addr    (csr_addr),
    .csr_wdata   (csr_wdata),
    .branch_done (branch_done),
    .mispredict  (mispredict),
    .csr_rdata   (csr_rdata),
    .enable      (enable)
  );

endmodule
